// File: verilog/stepper_settings.svh
`ifndef STEPPER_SETTINGS_SVH
`define STEPPER_SETTINGS_SVH

// axes sharing one speed table
`define AXIS_NBR 2

// signed step count and position
`define STEP_W 16

// one table word, a period in slot ticks
`define SPEED_W 16

`define ADDR_W 5
`define TBL_DEPTH (1 << `ADDR_W)

// ring length, >= AXIS_NBR and >= 3 for the two cycle table read
`define SLOT_NBR 8

`endif

// File: verilog/stepper_pkg.sv
`include "stepper_settings.svh"

package stepper_pkg;

	// signed step count or position
	typedef logic signed [`STEP_W-1:0] step_t;

	// period in slot ticks
	typedef logic [`SPEED_W-1:0] speed_t;

	// speed table index
	typedef logic [`ADDR_W-1:0] addr_t;

	// relative move request
	typedef struct packed {
		step_t step;
		addr_t cap;	// highest table index for this move
	} move_cmd_t;

	// per axis status seen by the host
	typedef struct packed {
		logic   busy;
		step_t  position;
		speed_t rt_speed;	// zero when idle
	} axis_status_t;

	// motor driver pins
	typedef struct packed {
		logic pulse;
		logic dir;	// 1 on negative moves
	} drive_t;

endpackage

// File: verilog/speed_table.sv
`timescale 1ns/10ps
`include "stepper_settings.svh"

module speed_table (
	input  logic                clk,
	input  logic                resetn,
	input  logic                i_load,
	input  logic                i_wr,
	input  stepper_pkg::speed_t i_data,
	input  stepper_pkg::addr_t  i_rd_addr,
	output stepper_pkg::speed_t o_rd_data,
	output stepper_pkg::addr_t  o_last_idx
);
	import stepper_pkg::*;

	speed_t mem [0:`TBL_DEPTH-1];
	addr_t  wr_ptr;
	addr_t  addr;
	logic   we;

	assign we = i_load & i_wr;

	// one port, writes win while loading
	assign addr = we ? wr_ptr : i_rd_addr;

	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= i_data;
		o_rd_data <= mem[addr];	// registered read
	end

	// write pointer restarts each load window
	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_ptr     <= '0;
			o_last_idx <= '0;
		end else if (!i_load) begin
			wr_ptr <= '0;
		end else if (i_wr) begin
			wr_ptr     <= wr_ptr + 1'b1;
			o_last_idx <= wr_ptr;	// fastest period sits here
		end
	end

endmodule

// File: verilog/table_arbiter.sv
`timescale 1ns/10ps
`include "stepper_settings.svh"

module table_arbiter (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic [`AXIS_NBR-1:0] i_rd_en,
	input  stepper_pkg::addr_t   i_rd_addr [`AXIS_NBR],
	output logic [`AXIS_NBR-1:0] o_tick,
	output stepper_pkg::addr_t   o_addr
);
	import stepper_pkg::*;

	logic [`SLOT_NBR-1:0] ring;
	addr_t                addr_or;

	// one-hot slot ring, bit 0 first after reset
	always_ff @(posedge clk) begin
		if (!resetn)
			ring <= {{(`SLOT_NBR-1){1'b0}}, 1'b1};
		else
			ring <= {ring[`SLOT_NBR-2:0], ring[`SLOT_NBR-1]};
	end

	// slots beyond the axis count stay unused
	assign o_tick = ring[`AXIS_NBR-1:0];

	// only one axis owns the slot, so a plain OR merges the addresses
	always_comb begin
		addr_or = '0;
		for (int n = 0; n < `AXIS_NBR; n++) begin
			if (i_rd_en[n] && ring[n])
				addr_or = addr_or | i_rd_addr[n];
		end
	end

	always_ff @(posedge clk) begin
		o_addr <= addr_or;	// first of two read cycles
	end

endmodule

// File: verilog/step_timer.sv
`timescale 1ns/10ps

module step_timer (
	input  logic                clk,
	input  logic                resetn,
	input  logic                i_tick,
	input  logic                i_load,
	input  stepper_pkg::speed_t i_period,
	input  logic                i_clear,
	output logic                o_expire
);
	import stepper_pkg::*;

	speed_t cnt;
	logic   run;

	always_ff @(posedge clk) begin
		if (!resetn || i_clear) begin
			cnt      <= '0;
			run      <= 1'b0;
			o_expire <= 1'b0;
		end else begin
			o_expire <= 1'b0;
			if (i_load) begin
				cnt <= i_period;
				run <= 1'b1;
			end else if (run && i_tick) begin
				// a period of 0 behaves as 1
				if (cnt <= speed_t'(1)) begin
					cnt      <= '0;
					run      <= 1'b0;
					o_expire <= 1'b1;
				end else begin
					cnt <= cnt - 1'b1;
				end
			end
		end
	end

endmodule

// File: verilog/motion_fsm.sv
`timescale 1ns/10ps
`include "stepper_settings.svh"

module motion_fsm (
	input  logic                      clk,
	input  logic                      resetn,
	input  logic                      i_tick,
	input  logic                      i_start,
	input  logic                      i_stop,
	input  stepper_pkg::move_cmd_t    i_cmd,
	input  stepper_pkg::addr_t        i_last_idx,
	input  stepper_pkg::speed_t       i_rd_data,
	output logic                      o_rd_en,
	output stepper_pkg::addr_t        o_rd_addr,
	output stepper_pkg::axis_status_t o_status,
	output stepper_pkg::drive_t       o_drive
);
	import stepper_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_fetch,
		st_wait,
		st_run,
		st_finish
	} state_t;

	state_t              state;
	addr_t               idx;
	addr_t               cap;
	logic [`STEP_W-1:0]  remain;	// unsigned, holds the full magnitude
	logic [`STEP_W-1:0]  idx_ext;
	logic                stop_req;
	logic [1:0]          tick_d;
	logic                timer_load;
	logic                expire;

	assign idx_ext = {{(`STEP_W-`ADDR_W){1'b0}}, idx};

	// read request goes out in our own slot
	assign o_rd_en   = (state == st_fetch) && i_tick;
	assign o_rd_addr = idx;

	// table data lands two cycles after the slot tick
	assign timer_load = (state == st_wait) && tick_d[1];

	step_timer u_timer (
		.clk      (clk),
		.resetn   (resetn),
		.i_tick   (i_tick),
		.i_load   (timer_load),
		.i_period (i_rd_data),
		.i_clear  (state == st_idle),
		.o_expire (expire)
	);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state    <= st_idle;
			idx      <= '0;
			cap      <= '0;
			remain   <= '0;
			stop_req <= 1'b0;
			tick_d   <= '0;
			o_status <= '0;
			o_drive  <= '0;
		end else begin
			tick_d <= {tick_d[0], i_tick};

			if (i_stop && o_status.busy)
				stop_req <= 1'b1;

			// pulse lasts one slot period
			if (state == st_run && expire)
				o_drive.pulse <= 1'b1;
			else if (tick_d[0])
				o_drive.pulse <= 1'b0;

			case (state)
				st_idle: begin
					if (i_start) begin
						idx           <= '0;
						cap           <= i_cmd.cap;
						remain        <= $unsigned(i_cmd.step[`STEP_W-1] ?
						                           -i_cmd.step : i_cmd.step);
						stop_req      <= 1'b0;
						o_drive.dir   <= i_cmd.step[`STEP_W-1];
						o_status.busy <= 1'b1;
						// a zero step ends in finish
						state         <= (i_cmd.step == '0) ? st_finish : st_fetch;
					end
				end
				st_fetch: begin
					if (i_tick)
						state <= st_wait;
				end
				st_wait: begin
					if (tick_d[1]) begin
						o_status.rt_speed <= i_rd_data;
						state             <= st_run;
					end
				end
				st_run: begin
					if (expire) begin
						remain <= remain - 1'b1;
						if (o_drive.dir)
							o_status.position <= o_status.position - 1'b1;
						else
							o_status.position <= o_status.position + 1'b1;
						state <= st_finish;
					end
				end
				st_finish: begin
					if (remain == '0 || (stop_req && idx == '0)) begin
						o_status.busy     <= 1'b0;
						o_status.rt_speed <= '0;
						state             <= st_idle;
					end else begin
						// slow down near the end or on stop
						if (remain <= idx_ext || stop_req)
							idx <= idx - 1'b1;
						else if (idx < cap && idx < i_last_idx)
							idx <= idx + 1'b1;
						state <= st_fetch;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// File: verilog/stepper_top.sv
`timescale 1ns/10ps
`include "stepper_settings.svh"

module stepper_top (
	input  logic                      clk,
	input  logic                      resetn,
	input  logic                      i_tbl_load,
	input  logic                      i_tbl_wr,
	input  stepper_pkg::speed_t       i_tbl_data,
	input  logic [`AXIS_NBR-1:0]      i_start,
	input  logic [`AXIS_NBR-1:0]      i_stop,
	input  stepper_pkg::move_cmd_t    i_cmd [`AXIS_NBR],
	output logic [`ADDR_W:0]          o_tbl_size,
	output stepper_pkg::axis_status_t o_status [`AXIS_NBR],
	output stepper_pkg::drive_t       o_drive [`AXIS_NBR]
);
	import stepper_pkg::*;

	speed_t               rd_data;	// shared by all axes, owner set by slot
	addr_t                rd_addr;
	addr_t                last_idx;
	logic [`AXIS_NBR-1:0] tick;
	logic [`AXIS_NBR-1:0] rd_en;
	addr_t                axis_addr [`AXIS_NBR];

	// depth is 2^ADDR_W
	assign o_tbl_size = {1'b1, {`ADDR_W{1'b0}}};

	speed_table u_table (
		.clk        (clk),
		.resetn     (resetn),
		.i_load     (i_tbl_load),
		.i_wr       (i_tbl_wr),
		.i_data     (i_tbl_data),
		.i_rd_addr  (rd_addr),
		.o_rd_data  (rd_data),
		.o_last_idx (last_idx)
	);

	table_arbiter u_arbiter (
		.clk       (clk),
		.resetn    (resetn),
		.i_rd_en   (rd_en),
		.i_rd_addr (axis_addr),
		.o_tick    (tick),
		.o_addr    (rd_addr)
	);

	for (genvar n = 0; n < `AXIS_NBR; n++) begin : g_axis
		motion_fsm u_axis (
			.clk        (clk),
			.resetn     (resetn),
			.i_tick     (tick[n]),
			.i_start    (i_start[n]),
			.i_stop     (i_stop[n]),
			.i_cmd      (i_cmd[n]),
			.i_last_idx (last_idx),
			.i_rd_data  (rd_data),
			.o_rd_en    (rd_en[n]),
			.o_rd_addr  (axis_addr[n]),
			.o_status   (o_status[n]),
			.o_drive    (o_drive[n])
		);
	end

endmodule

// File: tests/tb_stepper.sv
`timescale 1ns/10ps
`include "stepper_settings.svh"

module tb_stepper;
	import stepper_pkg::*;

	localparam int LOAD_NBR = 12;	// words loaded so last_idx ends at 11
	localparam int WAIT_MAX = 40000;

	logic                 clk;
	logic                 resetn;
	logic                 tbl_load;
	logic                 tbl_wr;
	speed_t               tbl_data;
	logic [`AXIS_NBR-1:0] start;
	logic [`AXIS_NBR-1:0] stop;
	move_cmd_t            cmd [`AXIS_NBR];
	logic [`ADDR_W:0]     tbl_size;
	axis_status_t         status [`AXIS_NBR];
	drive_t               drive [`AXIS_NBR];

	speed_t      tbl [0:`TBL_DEPTH-1];	// copy of the loaded periods
	logic [31:0] rng;
	int          cycle;
	int          pulse_cnt [`AXIS_NBR];
	int          cnt_base [`AXIS_NBR];
	int          last_rise [`AXIS_NBR];
	int          move_cycle [`AXIS_NBR];
	int          min_gap [`AXIS_NBR];
	logic        dir_exp [`AXIS_NBR];
	logic        pulse_prev [`AXIS_NBR];
	step_t       pos_start [`AXIS_NBR];
	int          ramp_idx [`AXIS_NBR];	// expected table index of the running step
	int          ramp_left [`AXIS_NBR];
	int          ramp_cap [`AXIS_NBR];
	logic        ramp_on [`AXIS_NBR];

	stepper_top i_dut (
		.clk        (clk),
		.resetn     (resetn),
		.i_tbl_load (tbl_load),
		.i_tbl_wr   (tbl_wr),
		.i_tbl_data (tbl_data),
		.i_start    (start),
		.i_stop     (stop),
		.i_cmd      (cmd),
		.o_tbl_size (tbl_size),
		.o_status   (status),
		.o_drive    (drive)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// advances the generator and returns a value in [0, span)
	function automatic int next_rand(input int span);
		rng = xorshift(rng);
		return int'(rng % span);
	endfunction

	// relative move end point wrapping like the position register
	function automatic step_t ref_position(input step_t from, input step_t step);
		return step_t'(from + step);
	endfunction

	// shortest legal pulse gap in clocks for a move with this cap
	function automatic int ref_min_gap(input int cap);
		int lim;
		int best;
		lim  = (cap < LOAD_NBR - 1) ? cap : LOAD_NBR - 1;
		best = int'(tbl[0]);
		for (int i = 1; i <= lim; i++) begin
			if (int'(tbl[i]) < best)
				best = int'(tbl[i]);
		end
		return `SLOT_NBR * best;
	endfunction

	// table index for the next step of a move without stop
	function automatic int ref_next_idx(input int idx, input int left, input int cap);
		if (left <= idx)
			return idx - 1;
		else if (idx < cap && idx < LOAD_NBR - 1)
			return idx + 1;
		return idx;
	endfunction

	task automatic stop_with_fail();
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic abort_run(input string why);
		$display("Error: %s", why);
		stop_with_fail();
	endtask

	task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (exp !== got) begin
			$display("Mismatch %s exp=%h got=%h", name, exp, got);
			stop_with_fail();
		end
	endtask

	task automatic wait_busy(input int n, input logic level);
		int t;
		t = 0;
		while (status[n].busy !== level) begin
			if (t == WAIT_MAX)
				abort_run($sformatf("axis %0d busy never went to %0b", n, level));
			@(negedge clk);
			t++;
		end
	endtask

	task automatic wait_pulses(input int n, input int count);
		int t;
		t = 0;
		while (pulse_cnt[n] - cnt_base[n] < count) begin
			if (t == WAIT_MAX)
				abort_run($sformatf("axis %0d gave too few pulses", n));
			@(negedge clk);
			t++;
		end
	endtask

	task automatic send_start(input int n, input int step, input int cap);
		@(negedge clk);
		cmd[n].step = step_t'(step);
		cmd[n].cap  = addr_t'(cap);
		start[n]    = 1'b1;
		@(negedge clk);
		start[n]    = 1'b0;
	endtask

	task automatic begin_move(input int n, input int step, input int cap);
		pos_start[n]  = status[n].position;
		cnt_base[n]   = pulse_cnt[n];
		dir_exp[n]    = (step < 0);
		min_gap[n]    = ref_min_gap(cap);
		move_cycle[n] = cycle;
		ramp_idx[n]   = 0;
		ramp_left[n]  = (step < 0) ? -step : step;
		ramp_cap[n]   = cap;
		ramp_on[n]    = 1'b1;
		send_start(n, step, cap);
		wait_busy(n, 1'b1);
	endtask

	task automatic end_move(input int n, input int step);
		wait_busy(n, 1'b0);
		check_equal($sformatf("o_status[%0d].position", n),
		            ref_position(pos_start[n], step_t'(step)), status[n].position);
		check_equal($sformatf("pulse count axis %0d", n),
		            (step < 0) ? -step : step, pulse_cnt[n] - cnt_base[n]);
		check_equal($sformatf("o_status[%0d].rt_speed", n), 0, status[n].rt_speed);
	endtask

	task automatic load_table();
		@(negedge clk);
		tbl_load = 1'b1;
		for (int i = 0; i < LOAD_NBR; i++) begin
			tbl[i]   = speed_t'(next_rand(8) + 2);
			tbl_wr   = 1'b1;
			tbl_data = tbl[i];
			@(negedge clk);
		end
		tbl_wr   = 1'b0;
		tbl_load = 1'b0;	// closing the window returns the pointer to 0
		@(negedge clk);
	endtask

	// pulse monitor sees the outputs from before the edge
	always @(posedge clk) begin
		if (resetn) begin
			cycle = cycle + 1;
			for (int n = 0; n < `AXIS_NBR; n++) begin
				if (drive[n].pulse && !pulse_prev[n]) begin
					check_equal($sformatf("o_drive[%0d].dir", n), dir_exp[n], drive[n].dir);
					if (last_rise[n] > move_cycle[n] && cycle - last_rise[n] < min_gap[n])
						abort_run($sformatf("pulse gap too short on axis %0d", n));
					if (ramp_on[n]) begin
						check_equal($sformatf("o_status[%0d].rt_speed", n), tbl[ramp_idx[n]],
						            status[n].rt_speed);
						ramp_left[n] = ramp_left[n] - 1;
						if (ramp_left[n] > 0)
							ramp_idx[n] = ref_next_idx(ramp_idx[n], ramp_left[n], ramp_cap[n]);
					end
					last_rise[n] = cycle;
					pulse_cnt[n] = pulse_cnt[n] + 1;
				end
				pulse_prev[n] = drive[n].pulse;
			end
		end
	end

	initial begin
		int cap0;
		int cap1;
		int cnt;
		clk      = 1'b0;
		resetn   = 1'b0;
		tbl_load = 1'b0;
		tbl_wr   = 1'b0;
		tbl_data = '0;
		start    = '0;
		stop     = '0;
		rng      = 32'd5;
		cycle    = 0;
		for (int n = 0; n < `AXIS_NBR; n++) begin
			cmd[n]        = '0;
			pulse_cnt[n]  = 0;
			cnt_base[n]   = 0;
			last_rise[n]  = -1;
			move_cycle[n] = 0;
			min_gap[n]    = 0;
			dir_exp[n]    = 1'b0;
			pulse_prev[n] = 1'b0;
			pos_start[n]  = '0;
			ramp_idx[n]   = 0;
			ramp_left[n]  = 0;
			ramp_cap[n]   = 0;
			ramp_on[n]    = 1'b0;
		end
		foreach (tbl[i])
			tbl[i] = '0;

		repeat (8) @(negedge clk);
		resetn = 1'b1;
		@(negedge clk);

		// idle state after reset
		for (int n = 0; n < `AXIS_NBR; n++) begin
			check_equal($sformatf("o_drive[%0d].pulse", n), 0, drive[n].pulse);
			check_equal($sformatf("o_drive[%0d].dir", n), 0, drive[n].dir);
			check_equal($sformatf("o_status[%0d].busy", n), 0, status[n].busy);
			check_equal($sformatf("o_status[%0d].rt_speed", n), 0, status[n].rt_speed);
		end
		check_equal("o_tbl_size", `TBL_DEPTH, tbl_size);

		load_table();

		// positive then negative move on axis 0
		begin_move(0, 10 + next_rand(20), 3 + next_rand(13));
		end_move(0, int'(cmd[0].step));
		begin_move(0, -(8 + next_rand(16)), 3 + next_rand(13));
		end_move(0, int'(cmd[0].step));

		// both axes at once
		cap0 = 3 + next_rand(13);
		cap1 = (cap0 + 4) % 16;
		begin_move(0, 20 + next_rand(20), cap0);
		begin_move(1, -(15 + next_rand(20)), cap1);
		end_move(0, int'(cmd[0].step));
		end_move(1, int'(cmd[1].step));

		// second start during a move must be dropped
		begin_move(0, 12, 5);
		send_start(0, -7, 2);
		end_move(0, 12);

		// stop in the middle of a long move
		begin_move(1, -300, 15);
		wait_pulses(1, 10);
		stop[1]    = 1'b1;
		ramp_on[1] = 1'b0;	// ramp down timing follows the stop
		@(negedge clk);
		stop[1] = 1'b0;
		wait_busy(1, 1'b0);
		cnt = pulse_cnt[1] - cnt_base[1];
		if (cnt >= 300)
			abort_run("stop did not shorten the move on axis 1");
		check_equal("o_status[1].position", step_t'(int'(pos_start[1]) - cnt),
		            status[1].position);
		check_equal("o_status[1].rt_speed", 0, status[1].rt_speed);

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: tb.f
+incdir+verilog
verilog/stepper_pkg.sv
verilog/speed_table.sv
verilog/table_arbiter.sv
verilog/step_timer.sv
verilog/motion_fsm.sv
verilog/stepper_top.sv
tests/tb_stepper.sv

// File: Bender.yml
package:
  name: stepper

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/stepper_pkg.sv
      - verilog/speed_table.sv
      - verilog/table_arbiter.sv
      - verilog/step_timer.sv
      - verilog/motion_fsm.sv
      - verilog/stepper_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/tb_stepper.sv
